/* vlog.f */
hdl/audio_pkg.sv
hdl/sample_settle.sv
hdl/audio_mixer.sv
hdl/boost_compressor.sv
hdl/audio_out.sv
tests/clk_gen.sv
tests/audio_out_tb.sv

/* Makefile */
# Verilator build for the audio output path

VERILATOR ?= verilator
TOP ?= audio_out_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
JOBS ?= 4

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# Passes only when the simulation prints the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx 'TEST PASS'; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

/* tests/audio_out_tb.sv */
module audio_out_tb import audio_pkg::*; ();

	logic clk_sys;
	logic reset;
	audio_cfg_t cfg;
	stereo_t card_sample;
	logic speaker;
	stereo_t synth_sample;
	stereo_t audio;

	logic [31:0] rng_state = 32'h2a504039;
	int check_count = 0;
	int fail_count = 0;

	clk_gen i_clk_gen (.clk_sys(clk_sys), .reset(reset));

	audio_out i_audio_out (
		.clk_sys(clk_sys),
		.reset(reset),
		.cfg(cfg),
		.card_sample(card_sample),
		.speaker(speaker),
		.synth_sample(synth_sample),
		.audio(audio)
	);

	//////////////////////////////////////////////////
	// Random numbers and reference model
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int to_s16(input int v);
		return int'($signed(v[15:0]));
	endfunction

	function automatic int rand_sample();
		logic [31:0] r;
		r = next_rand();
		return to_s16(int'(r[31:16]));
	endfunction

	function automatic int clamp16(input int v);
		if (v > 32767)
			return 32767;
		if (v < -32768)
			return -32768;
		return v;
	endfunction

	// Card plus speaker step plus synth unless muted, clamped
	function automatic int mix_model(input int card, input int synth, input logic spk,
			input logic [1:0] vol, input logic mute);
		int sum;
		sum = card;
		if (spk)
			sum = sum + (2048 << vol);
		if (!mute)
			sum = sum + synth;
		return clamp16(sum);
	endfunction

	function automatic int boost_model(input int x, input boost_mode_t mode);
		int mag;
		int knee;
		int base;
		int gain;
		int div;
		int y;
		if (mode == boost_off)
			return x;
		knee = (mode == boost_4x) ? 7400 : 14044;
		gain = (mode == boost_4x) ? 4 : 2;
		div = (mode == boost_4x) ? 8 : 4;
		base = knee * gain;
		mag = (x < 0) ? -x : x;
		y = (mag < knee) ? mag * gain : (mag - knee) / div + base;
		return clamp16((x < 0) ? -y : y);
	endfunction

	function automatic stereo_t make_stereo(input int l, input int r);
		stereo_t s;
		s.left = l[15:0];
		s.right = r[15:0];
		return s;
	endfunction

	function automatic audio_cfg_t make_cfg(input logic [1:0] vol, input boost_mode_t b,
			input logic present, input logic disable_synth);
		audio_cfg_t c;
		c.speaker_vol = vol;
		c.boost = b;
		c.synth_present = present;
		c.synth_disable = disable_synth;
		return c;
	endfunction

	//////////////////////////////////////////////////
	// Drive, wait and check
	//////////////////////////////////////////////////

	task automatic hold_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(posedge clk_sys);
	endtask

	task automatic check_audio(input int exp_l, input int exp_r);
		int got_l;
		int got_r;
		got_l = audio.left;
		got_r = audio.right;
		check_count += 2;
		assert (got_l == exp_l) else begin
			$display("CHECK FAILED at %0t: left expected %0d got %0d", $time, exp_l, got_l);
			fail_count++;
		end
		assert (got_r == exp_r) else begin
			$display("CHECK FAILED at %0t: right expected %0d got %0d", $time, exp_r, got_r);
			fail_count++;
		end
	endtask

	// Apply one input set, hold it, then compare at the falling edge
	task automatic run_trial(input audio_cfg_t c, input int card_l, input int card_r,
			input logic spk, input int syn_l, input int syn_r);
		logic mute;
		int exp_l;
		int exp_r;
		mute = c.synth_present & c.synth_disable;
		@(posedge clk_sys);
		cfg <= c;
		card_sample <= make_stereo(card_l, card_r);
		speaker <= spk;
		synth_sample <= make_stereo(syn_l, syn_r);
		hold_cycles(10);
		exp_l = boost_model(mix_model(card_l, syn_l, spk, c.speaker_vol, mute), c.boost);
		exp_r = boost_model(mix_model(card_r, syn_r, spk, c.speaker_vol, mute), c.boost);
		@(negedge clk_sys);
		check_audio(exp_l, exp_r);
	endtask

	task automatic report_test(input string name, input int checks0, input int fails0);
		$display("%s: %0d checks, %0d failed", name, check_count - checks0,
			fail_count - fails0);
	endtask

	task automatic random_trial(input boost_mode_t b, input logic present,
			input logic disable_synth);
		logic [31:0] r;
		r = next_rand();
		run_trial(make_cfg(r[1:0], b, present, disable_synth), rand_sample(),
			rand_sample(), r[2], rand_sample(), rand_sample());
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int c0;
		int f0;
		int a_l;
		int a_r;
		int b_l;
		int b_r;
		int knee;
		logic released;
		cfg = '0;
		card_sample = '0;
		speaker = 1'b0;
		synth_sample = '0;

		// Reset release, with its own timeout
		released = 1'b0;
		for (int i = 0; i < 64 && !released; i++) begin
			@(posedge clk_sys);
			released = !reset;
		end

		if (!released) begin
			$display("Timeout: reset was still asserted after 64 clock cycles");
			$display("TEST FAIL");
		end else begin
			c0 = check_count;
			f0 = fail_count;
			@(negedge clk_sys);
			check_audio(0, 0);
			report_test("reset", c0, f0);

			c0 = check_count;
			f0 = fail_count;
			for (int i = 0; i < 40; i++)
				random_trial(boost_off, 1'b0, 1'b0);
			report_test("plain mixing", c0, f0);

			c0 = check_count;
			f0 = fail_count;
			run_trial(make_cfg(2'd3, boost_off, 1'b0, 1'b0), 32000, -32000, 1'b1, 32000, -32768);
			run_trial(make_cfg(2'd0, boost_off, 1'b0, 1'b0), -32768, 32767, 1'b0, -32768, 32767);
			for (int i = 0; i < 10; i++) begin
				a_l = 30000 + (rand_sample() & 2047);
				a_r = -30000 - (rand_sample() & 2047);
				run_trial(make_cfg(2'd1, boost_off, 1'b0, 1'b0), a_l, a_r, 1'b0, a_l, a_r);
			end
			report_test("saturation", c0, f0);

			c0 = check_count;
			f0 = fail_count;
			for (int i = 0; i < 16; i++)
				random_trial(boost_off, i[0], i[1]);
			report_test("synth muting", c0, f0);

			// Edge cases around each knee, then random mixes
			c0 = check_count;
			f0 = fail_count;
			for (int m = 1; m <= 2; m++) begin
				knee = (m == 2) ? 7400 : 14044;
				for (int d = -1; d <= 1; d++)
					run_trial(make_cfg(2'd0, boost_mode_t'(m), 1'b0, 1'b0), knee + d,
						-(knee + d), 1'b0, 0, 0);
				run_trial(make_cfg(2'd0, boost_mode_t'(m), 1'b0, 1'b0), 32767, -32768,
					1'b0, 0, 0);
				for (int i = 0; i < 15; i++)
					random_trial(boost_mode_t'(m), 1'b0, 1'b0);
			end
			report_test("boost curves", c0, f0);

			// Toggling card input must never reach the output
			c0 = check_count;
			f0 = fail_count;
			a_l = rand_sample();
			a_r = rand_sample();
			b_l = rand_sample();
			b_r = rand_sample();
			run_trial(make_cfg(2'd0, boost_off, 1'b0, 1'b0), a_l, a_r, 1'b0, 0, 0);
			for (int i = 0; i < 20; i++) begin
				@(posedge clk_sys);
				card_sample <= i[0] ? make_stereo(to_s16(b_l ^ 255), to_s16(b_r ^ 255))
					: make_stereo(b_l, b_r);
				@(negedge clk_sys);
				check_audio(a_l, a_r);
			end
			hold_cycles(10);
			@(negedge clk_sys);
			check_audio(to_s16(b_l ^ 255), to_s16(b_r ^ 255));
			report_test("settling", c0, f0);

			$display("checks passed %0d, failed %0d", check_count - fail_count, fail_count);
			if (fail_count == 0)
				$display("TEST PASS");
			else
				$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* tests/clk_gen.sv */
module clk_gen (
	output logic clk_sys,
	output logic reset
);

	// Period of 20
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Reset held for 16 rising edges, released on an edge
	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

/* hdl/audio_out.sv */
module audio_out import audio_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input audio_cfg_t cfg,

	// Sound card, asynchronous to clk_sys
	input stereo_t card_sample,

	// PC speaker and MIDI synth, already synchronous
	input logic speaker,
	input stereo_t synth_sample,

	output stereo_t audio
);

	stereo_t card_stable;
	stereo_t mix;

	//////////////////////////////////////////////////
	// Settle, mix, compress
	//////////////////////////////////////////////////

	sample_settle i_sample_settle (
		.clk_sys(clk_sys),
		.reset(reset),
		.card_sample(card_sample),
		.card_stable(card_stable)
	);

	audio_mixer i_audio_mixer (
		.clk_sys(clk_sys),
		.reset(reset),
		.cfg(cfg),
		.card_stable(card_stable),
		.speaker(speaker),
		.synth_sample(synth_sample),
		.mix(mix)
	);

	boost_compressor i_boost_compressor (
		.clk_sys(clk_sys),
		.reset(reset),
		.cfg(cfg),
		.mix(mix),
		.audio(audio)
	);

endmodule

/* hdl/boost_compressor.sv */
module boost_compressor import audio_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input audio_cfg_t cfg,
	input stereo_t mix,
	output stereo_t audio
);

	//////////////////////////////////////////////////
	// Two-knee curve on the magnitude
	//////////////////////////////////////////////////

	function automatic sample_t compress(input sample_t x, input logic use_4x);
		logic [sample_w:0] ext;
		logic [sample_w:0] mag;
		logic [sample_w:0] curve_2x;
		logic [sample_w:0] curve_4x;
		logic [sample_w:0] res;
		logic [sample_w:0] neg;
		ext = {x[sample_w-1], x};
		// 17 bits so that -32768 gives 32768
		mag = ext[sample_w] ? -ext : ext;

		if (mag < comp_knee_2x)
			curve_2x = mag * comp_gain_2x;
		else
			curve_2x = (mag - comp_knee_2x) / comp_div_2x + comp_base_2x;

		if (mag < comp_knee_4x)
			curve_4x = mag * comp_gain_4x;
		else
			curve_4x = (mag - comp_knee_4x) / comp_div_4x + comp_base_4x;

		res = use_4x ? curve_4x : curve_2x;
		neg = -res;

		// Top of both curves lands a few counts past full scale, so clamp
		if (!ext[sample_w])
			return (res[sample_w] | res[sample_w-1]) ? 16'sh7fff : res[sample_w-1:0];
		if (res[sample_w] | (res[sample_w-1] & |res[sample_w-2:0]))
			return 16'sh8000;
		return neg[sample_w-1:0];
	endfunction

	// Same single register in every mode keeps the latency fixed
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio <= '0;
		end else begin
			case (cfg.boost)
				boost_2x: begin
					audio.left <= compress(mix.left, 1'b0);
					audio.right <= compress(mix.right, 1'b0);
				end
				boost_4x: begin
					audio.left <= compress(mix.left, 1'b1);
					audio.right <= compress(mix.right, 1'b1);
				end
				default: audio <= mix;
			endcase
		end
	end

	boost_off_pass: assert property (
		@(posedge clk_sys) disable iff (reset)
		(cfg.boost == boost_off) |=> (audio == $past(mix))
	);

endmodule

/* hdl/audio_mixer.sv */
module audio_mixer import audio_pkg::*; (
	input logic clk_sys,
	input logic reset,
	input audio_cfg_t cfg,
	input stereo_t card_stable,
	input logic speaker,
	input stereo_t synth_sample,
	output stereo_t mix
);

	// One guard bit above sum_w so full-scale card and synth plus speaker cannot wrap
	logic signed [sum_w:0] sum_l_q;
	logic signed [sum_w:0] sum_r_q;
	logic [sum_w:0] spk_term;
	logic synth_mute;

	function automatic logic signed [sum_w:0] channel_sum(
		input sample_t card,
		input sample_t synth,
		input logic [sum_w:0] spk,
		input logic mute
	);
		logic signed [sum_w:0] acc;
		acc = {{(sum_w + 1 - sample_w){card[sample_w-1]}}, card};
		acc = acc + $signed(spk);
		if (!mute)
			acc = acc + {{(sum_w + 1 - sample_w){synth[sample_w-1]}}, synth};
		return acc;
	endfunction

	// True when every bit above the sample sign matches it
	function automatic logic fits_sample(input logic signed [sum_w:0] acc);
		return (&acc[sum_w:sample_w-1]) || !(|acc[sum_w:sample_w-1]);
	endfunction

	function automatic sample_t saturate(input logic signed [sum_w:0] acc);
		if (fits_sample(acc))
			return acc[sample_w-1:0];
		return acc[sum_w] ? 16'sh8000 : 16'sh7fff;
	endfunction

	// Speaker step of 2048, 4096, 8192 or 16384
	assign spk_term = speaker ? ({1'b0, spk_unit} << cfg.speaker_vol) : '0;

	// Synth only drops out when it is there and switched off
	assign synth_mute = cfg.synth_present & cfg.synth_disable;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sum_l_q <= '0;
			sum_r_q <= '0;
			mix <= '0;
		end else begin
			sum_l_q <= channel_sum(card_stable.left, synth_sample.left, spk_term, synth_mute);
			sum_r_q <= channel_sum(card_stable.right, synth_sample.right, spk_term, synth_mute);
			mix.left <= saturate(sum_l_q);
			mix.right <= saturate(sum_r_q);
		end
	end

	// In-range sums pass through the clamp untouched
	mix_left_pass: assert property (
		@(posedge clk_sys) disable iff (reset)
		fits_sample(sum_l_q) |=> (mix.left == $past(sum_l_q[sample_w-1:0]))
	);

	mix_right_pass: assert property (
		@(posedge clk_sys) disable iff (reset)
		fits_sample(sum_r_q) |=> (mix.right == $past(sum_r_q[sample_w-1:0]))
	);

endmodule

/* hdl/sample_settle.sv */
module sample_settle import audio_pkg::*; (
	input logic clk_sys,
	input logic reset,

	// Sound-card samples from the other clock domain
	input stereo_t card_sample,

	output stereo_t card_stable
);

	// First and second capture stage
	stereo_t cap0;
	stereo_t cap1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cap0 <= '0;
			cap1 <= '0;
			card_stable <= '0;
		end else begin
			cap0 <= card_sample;
			cap1 <= cap0;

			// Each channel settles on its own
			if (cap0.left == cap1.left)
				card_stable.left <= cap1.left;
			if (cap0.right == cap1.right)
				card_stable.right <= cap1.right;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	// A torn capture must never reach the mixer
	settle_left_held: assert property (
		@(posedge clk_sys) disable iff (reset)
		(cap0.left != cap1.left) |=> $stable(card_stable.left)
	);

	settle_right_held: assert property (
		@(posedge clk_sys) disable iff (reset)
		(cap0.right != cap1.right) |=> $stable(card_stable.right)
	);

endmodule

/* hdl/audio_pkg.sv */
package audio_pkg;

	//////////////////////////////////////////////////
	// Sample widths
	//////////////////////////////////////////////////

	localparam int sample_w = 16;

	// Unsaturated mix width before the clamp to 16 bits
	localparam int sum_w = 17;

	// Speaker amplitude at volume 0, doubled per volume step
	localparam logic [sum_w-1:0] spk_unit = 17'd2048;

	//////////////////////////////////////////////////
	// Compressor curves
	//////////////////////////////////////////////////

	// All values are magnitudes, one bit wider than a sample so that 32768 fits

	// 2x curve
	localparam logic [sample_w:0] comp_knee_2x = 17'd14044;
	localparam logic [sample_w:0] comp_base_2x = 17'd28088;
	localparam logic [sample_w:0] comp_gain_2x = 17'd2;
	localparam logic [sample_w:0] comp_div_2x = 17'd4;

	// 4x curve
	localparam logic [sample_w:0] comp_knee_4x = 17'd7400;
	localparam logic [sample_w:0] comp_base_4x = 17'd29600;
	localparam logic [sample_w:0] comp_gain_4x = 17'd4;
	localparam logic [sample_w:0] comp_div_4x = 17'd8;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	typedef logic signed [sample_w-1:0] sample_t;

	// Left sits in the upper half
	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	typedef enum logic [1:0] {
		boost_off = 2'd0,
		boost_2x = 2'd1,
		boost_4x = 2'd2
	} boost_mode_t;

	// Static settings, held while audio runs
	typedef struct packed {
		logic [1:0] speaker_vol;
		boost_mode_t boost;
		logic synth_present;
		logic synth_disable;
	} audio_cfg_t;

endpackage
